/* common/fp_format_pkg.sv */
`default_nettype none

package fp_format_pkg;

    // binary32 field widths.
    localparam int EXP_BITS = 8;
    localparam int FRAC_BITS = 23;

    localparam int WORD_BITS = 32; // sign + exponent + stored fraction.

    // exponent value that encodes 2^0.
    localparam int EXP_BIAS = 127;

    // field view of a float word, sign in the top bit.
    typedef struct packed {
        logic                 sign;
        logic [EXP_BITS-1:0]  exp;
        logic [FRAC_BITS-1:0] frac;
    } fp_fields_t;

    // A float word is moved around as raw bits and taken apart as fields.
    // Both views cover the same 32 bits.
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        fp_fields_t           f;
    } fp_word_t;

endpackage

`default_nettype wire

/* common/fpu_ctrl_pkg.sv */
`default_nettype none

package fpu_ctrl_pkg;

    // command port operation codes.
    typedef enum logic [1:0] {
        FPU_ADD = 2'd0,
        FPU_SUB = 2'd1, // add with the sign of b flipped.
        FPU_MUL = 2'd2
    } fpu_op_t;

    // adder sequencer, idle is the only state with ready high.
    typedef enum logic [2:0] {
        ADD_IDLE  = 3'd0,
        ADD_ALIGN = 3'd1,
        ADD_SIGN  = 3'd2,
        ADD_SUM   = 3'd3,
        ADD_NORM  = 3'd4
    } add_state_t;

    // multiplier sequencer around the shift-and-add core.
    typedef enum logic [1:0] {
        MUL_IDLE  = 2'd0,
        MUL_START = 2'd1,
        MUL_MULT  = 2'd2,
        MUL_NORM  = 2'd3
    } mul_state_t;

endpackage

`default_nettype wire

/* fp_mul/seq_mul.sv */
`default_nettype none

module seq_mul #(
    parameter int MUL_SHIFT = 12
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         start,
    input  wire  [23:0] x,
    input  wire  [23:0] y,
    output logic [47:0] p,
    output logic        ready
);

    localparam int W = 24;
    localparam int PW = 2 * W;
    localparam int BITS = (MUL_SHIFT < W) ? MUL_SHIFT : W;
    localparam int STEPS = (W + BITS - 1) / BITS;
    localparam int XW = STEPS * BITS; // x padded at the top to whole steps.
    localparam int CW = $clog2(STEPS + 1);

    logic [CW-1:0] count;
    logic [XW-1:0] x_q;
    logic [W-1:0]  y_q;
    logic [PW-1:0] acc;
    logic [PW-1:0] partial;

    // one slice of x times all of y per clock.
    assign partial = PW'(y_q) * PW'(x_q[XW-1 -: BITS]);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CW'(STEPS);
        end else if (!ready) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x_q <= XW'(x);
            y_q <= y;
            acc <= '0;
        end else if (!ready) begin
            acc <= (acc << BITS) + partial;
            x_q <= x_q << BITS;
        end
    end

    assign ready = (count == '0);
    assign p = acc;

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        count <= CW'(STEPS));

endmodule

`default_nettype wire

/* fp_mul/fp_mul.sv */
`default_nettype none

module fp_mul
    import fp_format_pkg::*;
    import fpu_ctrl_pkg::*;
#(
    parameter int MUL_SHIFT = 12
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      start,
    input  wire      fp_word_t a,
    input  wire      fp_word_t b,
    output fp_word_t product,
    output logic     ready
);

    localparam int MW = FRAC_BITS + 1;
    localparam int PW = 2 * MW;

    // The product of two fractions in [1,2) has its top bit one place higher,
    // so the bias is taken off less one.
    localparam logic [EXP_BITS-1:0] EXP_ADJ = EXP_BITS'(EXP_BIAS - 1);

    mul_state_t          state;
    fp_word_t            a_q;
    fp_word_t            b_q;
    logic                sign_q;
    logic [EXP_BITS-1:0] exp_q;
    logic [PW-1:0]       prod_q;

    logic [MW-1:0]       frac_a;
    logic [MW-1:0]       frac_b;
    logic                mul_start;
    logic                mul_ready;
    logic [PW-1:0]       mul_p;

    assign frac_a = (a_q.f.exp == '0) ? '0 : {1'b1, a_q.f.frac};
    assign frac_b = (b_q.f.exp == '0) ? '0 : {1'b1, b_q.f.frac};
    assign mul_start = (state == MUL_START);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= MUL_IDLE;
            sign_q <= 1'b0;
            exp_q  <= '0;
            prod_q <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (start) begin
                        a_q   <= a;
                        b_q   <= b;
                        state <= MUL_START;
                    end
                end
                MUL_START: begin
                    sign_q <= a_q.f.sign ^ b_q.f.sign;
                    exp_q  <= a_q.f.exp + b_q.f.exp;
                    state  <= MUL_MULT;
                end
                MUL_MULT: begin
                    if (mul_ready) begin
                        prod_q <= mul_p;
                        exp_q  <= exp_q - EXP_ADJ;
                        state  <= MUL_NORM;
                    end
                end
                MUL_NORM: begin
                    // at most one left shift, since both inputs had the hidden bit.
                    if (!prod_q[PW-1]) begin
                        if (prod_q == '0) begin
                            sign_q <= 1'b0;
                            exp_q  <= '0;
                        end else begin
                            prod_q <= prod_q << 1;
                            exp_q  <= exp_q - 1'b1;
                        end
                    end
                    state <= MUL_IDLE;
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    seq_mul #(
        .MUL_SHIFT (MUL_SHIFT)
    ) i_seq_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .x     (frac_a),
        .y     (frac_b),
        .p     (mul_p),
        .ready (mul_ready)
    );

    // truncated fraction, the bits below are dropped.
    assign product.raw = {sign_q, exp_q, prod_q[PW-2 -: FRAC_BITS]};
    assign ready = (state == MUL_IDLE);

endmodule

`default_nettype wire

/* fp_add/fp_add.sv */
`default_nettype none

module fp_add
    import fp_format_pkg::*;
    import fpu_ctrl_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  wire      start,
    input  wire      fp_word_t a,
    input  wire      fp_word_t b,
    output fp_word_t sum,
    output logic     ready
);

    localparam int MW = FRAC_BITS + 1; // fraction with the hidden bit.

    add_state_t          state;
    fp_word_t            a_q;
    fp_word_t            b_q;
    logic [MW:0]         al_a;
    logic [MW:0]         al_b;
    logic                sum_sign;
    logic                sign_q;
    logic [EXP_BITS-1:0] exp_q;
    logic [MW:0]         mag_q;

    logic [MW-1:0]       frac_a;
    logic [MW-1:0]       frac_b;
    logic [EXP_BITS-1:0] diff_ab;
    logic [EXP_BITS-1:0] diff_ba;
    logic [MW+1:0]       sum_full;
    logic [MW+1:0]       sum_neg;

    // a zero exponent reads as zero, so no hidden bit is set.
    assign frac_a = (a_q.f.exp == '0) ? '0 : {1'b1, a_q.f.frac};
    assign frac_b = (b_q.f.exp == '0) ? '0 : {1'b1, b_q.f.frac};
    assign diff_ab = a_q.f.exp - b_q.f.exp;
    assign diff_ba = b_q.f.exp - a_q.f.exp;

    // the aligned values are two's complement after the sign state.
    assign sum_full = {al_a[MW], al_a} + {al_b[MW], al_b};
    assign sum_neg = -sum_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ADD_IDLE;
            sign_q <= 1'b0;
            exp_q  <= '0;
            mag_q  <= '0;
        end else begin
            case (state)
                ADD_IDLE: begin
                    if (start) begin
                        a_q   <= a;
                        b_q   <= b;
                        state <= ADD_ALIGN;
                    end
                end
                ADD_ALIGN: begin
                    // The larger exponent is kept and the other fraction moves right.
                    if (a_q.f.exp > b_q.f.exp) begin
                        al_a  <= {1'b0, frac_a};
                        al_b  <= {1'b0, frac_b >> diff_ab};
                        exp_q <= a_q.f.exp;
                    end else begin
                        al_a  <= {1'b0, frac_a >> diff_ba};
                        al_b  <= {1'b0, frac_b};
                        exp_q <= b_q.f.exp;
                    end
                    state <= ADD_SIGN;
                end
                ADD_SIGN: begin
                    if (a_q.f.sign == b_q.f.sign) begin
                        sum_sign <= a_q.f.sign;
                    end else begin
                        sum_sign <= 1'b0; // the sum's own sign decides below.
                        if (a_q.f.sign) begin
                            al_a <= -al_a;
                        end else begin
                            al_b <= -al_b;
                        end
                    end
                    state <= ADD_SUM;
                end
                ADD_SUM: begin
                    if (sum_full[MW+1]) begin
                        sign_q <= 1'b1;
                        mag_q  <= sum_neg[MW:0];
                    end else begin
                        sign_q <= sum_sign;
                        mag_q  <= sum_full[MW:0];
                    end
                    state <= ADD_NORM;
                end
                ADD_NORM: begin
                    if (mag_q[MW]) begin
                        mag_q <= mag_q >> 1; // carry out of the hidden bit.
                        exp_q <= exp_q + 1'b1;
                        state <= ADD_IDLE;
                    end else if (!mag_q[MW-1]) begin
                        if (mag_q == '0) begin
                            sign_q <= 1'b0; // exact zero is returned as +0.
                            exp_q  <= '0;
                            state  <= ADD_IDLE;
                        end else begin
                            mag_q <= mag_q << 1;
                            exp_q <= exp_q - 1'b1;
                        end
                    end else begin
                        state <= ADD_IDLE;
                    end
                end
                default: state <= ADD_IDLE;
            endcase
        end
    end

    assign sum.raw = {sign_q, exp_q, mag_q[FRAC_BITS-1:0]};
    assign ready = (state == ADD_IDLE);

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {ADD_IDLE, ADD_ALIGN, ADD_SIGN, ADD_SUM, ADD_NORM});

endmodule

`default_nettype wire

/* hw/fpu_top.sv */
`default_nettype none

module fpu_top
    import fp_format_pkg::*;
    import fpu_ctrl_pkg::*;
#(
    parameter int MUL_SHIFT = 12
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      start,
    input  wire      fpu_op_t op,
    input  wire      fp_word_t a,
    input  wire      fp_word_t b,
    output fp_word_t result,
    output logic     ready
);

    fpu_op_t  op_sel;
    fp_word_t b_add;
    fp_word_t sum;
    fp_word_t product;
    logic     add_start;
    logic     mul_start;
    logic     add_ready;
    logic     mul_ready;

    // exactly one unit sees the start pulse.
    assign add_start = start && (op == FPU_ADD || op == FPU_SUB);
    assign mul_start = start && (op == FPU_MUL);

    always_comb begin
        b_add = b;
        if (op == FPU_SUB) begin
            b_add.f.sign = ~b.f.sign; // a - b is a + (-b).
        end
    end

    // the last operation decides which unit drives the outputs.
    always_ff @(posedge clk) begin
        if (rst) begin
            op_sel <= FPU_ADD;
        end else if (start) begin
            op_sel <= op;
        end
    end

    assign result = (op_sel == FPU_MUL) ? product : sum;
    assign ready  = (op_sel == FPU_MUL) ? mul_ready : add_ready;

    fp_add i_fp_add (
        .clk   (clk),
        .rst   (rst),
        .start (add_start),
        .a     (a),
        .b     (b_add),
        .sum   (sum),
        .ready (add_ready)
    );

    fp_mul #(
        .MUL_SHIFT (MUL_SHIFT)
    ) i_fp_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (a),
        .b       (b),
        .product (product),
        .ready   (mul_ready)
    );

    a_start_when_ready: assert property (@(posedge clk) disable iff (rst)
        start |-> ready);

endmodule

`default_nettype wire

/* verification/fpu_tb.sv */
`default_nettype none

module fpu_tb
    import fp_format_pkg::*;
    import fpu_ctrl_pkg::*;
();

    localparam int    RESET_CYCLES = 16;
    localparam int    CMD_CYCLES   = 64; // the longest adder normalize stays far below this.
    localparam int    HOLD_CYCLES  = 3;
    localparam string STIM_FILE    = "verification/fpu_stim.txt";

    logic     clk;
    logic     rst;
    logic     start;
    fpu_op_t  op;
    fp_word_t a;
    fp_word_t b;
    fp_word_t result;
    logic     ready;

    // one entry per command line of the stimulus file.
    fpu_op_t  cmd_op[$];
    fp_word_t cmd_a[$];
    fp_word_t cmd_b[$];
    fp_word_t cmd_exp[$];
    bit       loaded;

    fpu_top #(
        .MUL_SHIFT (12)
    ) i_fpu_top (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .ready  (ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input fp_word_t got, input fp_word_t expected);
        if (got.raw !== expected.raw) begin
            abort_run($sformatf("error result: got %h, expected %h", got.raw, expected.raw));
        end
    endtask

    task automatic check_ready(input logic got, input logic expected);
        if (got !== expected) begin
            abort_run($sformatf("error ready: got %h, expected %h", got, expected));
        end
    endtask

    task automatic load_stimulus();
        int                   fd;
        int                   code;
        string                line;
        logic [1:0]           op_v;
        logic [WORD_BITS-1:0] a_v;
        logic [WORD_BITS-1:0] b_v;
        logic [WORD_BITS-1:0] e_v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) != "#") begin // comment lines start with a hash.
                    code = $sscanf(line, "%h %h %h %h", op_v, a_v, b_v, e_v);
                    if (code == 4) begin
                        cmd_op.push_back(fpu_op_t'(op_v));
                        cmd_a.push_back(fp_word_t'(a_v));
                        cmd_b.push_back(fp_word_t'(b_v));
                        cmd_exp.push_back(fp_word_t'(e_v));
                    end else if (code > 0) begin
                        abort_run({"malformed stimulus line: ", line});
                    end
                end
            end
            $fclose(fd);
            if (cmd_op.size() == 0) begin
                abort_run("the stimulus file holds no commands");
            end
        end
    endtask

    task automatic run_command(input fpu_op_t cmd, input fp_word_t opa, input fp_word_t opb,
                               input fp_word_t expected);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        start <= 1'b1;
        op    <= cmd;
        a     <= opa;
        b     <= opb;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_ready(ready, 1'b0); // Busy from the cycle after start.
        while (!ready) begin
            @(negedge clk);
        end
        check_result(result, expected);
        // the result has to hold while the unit sits idle.
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_ready(ready, 1'b1);
            check_result(result, expected);
        end
    endtask

    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + CMD_CYCLES * cmd_op.size()) @(posedge clk);
        abort_run("ready never returned high before the watchdog ran out");
    end

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        op    = FPU_ADD;
        a     = '0;
        b     = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_ready(ready, 1'b1);
        check_result(result, '0); // nothing has run yet.
        foreach (cmd_op[i]) begin
            run_command(cmd_op[i], cmd_a[i], cmd_b[i], cmd_exp[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/fpu_stim.txt */
# columns: op (0 add, 1 sub, 2 mul), operand a, operand b, expected result, all hex
# expected values truncate the fraction, read a zero exponent as zero and give +0 for zero
0 3f800000 40000000 40400000
0 3fc00000 3e800000 3fe00000
0 3f800000 3f800000 40000000
0 3f800000 3f800001 40000000
1 40400000 3f800000 40000000
1 3f800000 40400000 c0000000
1 3fc00000 3fa00000 3e800000
1 3f800000 3f7fffff 34000000
1 3fc00000 3fc00000 00000000
0 c0400000 3f800000 c0000000
0 40000000 bf000000 3fc00000
0 3f800000 bf800000 00000000
2 3fc00000 40000000 40400000
2 c0400000 3f000000 bfc00000
2 3fc00000 3fc00000 40100000
2 bfe00000 bfe00000 40440000
2 40800000 3e800000 3f800000
2 bf800000 40000000 c0000000
2 3f800001 3f800001 3f800002
2 00400000 40400000 00000000
2 c0400000 00000000 00000000
0 00000000 3fc00000 3fc00000
0 00400000 c0400000 c0400000
0 3fc00000 80123456 3fc00000
1 3fc00000 00400000 3fc00000

/* src.f */
common/fp_format_pkg.sv
common/fpu_ctrl_pkg.sv
fp_mul/seq_mul.sv
fp_mul/fp_mul.sv
fp_add/fp_add.sv
hw/fpu_top.sv
verification/fpu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb -f src.f -o fpu_sim &&
./obj_dir/fpu_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
